//--- Makefile
VERILATOR ?= verilator
TOP       ?= cart_mapper_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, check $(LOG) for the pass message"
	@echo "make clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
hdl/cart_pkg.sv
hdl/io_port_decode.sv
hdl/bank_window.sv
hdl/window_select.sv
hdl/cart_mapper.sv
bench/cart_mapper_sva.sv
bench/cart_mapper_tb.sv

//--- bench/cart_mapper_sva.sv
`timescale 1ns/1ns

module cart_mapper_sva (
    input logic                nWE,
    input logic                rst_n,
    input cart_pkg::host_bus_t host,
    input logic                data_oe,
    input logic                psram1_sel_n,
    input logic                psram2_sel_n,
    input logic                sram_sel_n,
    input logic                psram_lb_n,
    input logic                psram_ub_n
);

    // outputs are combinational so sample them mid cycle
    one_select_low: assert property (@(negedge nWE) disable iff (!rst_n)
        $countones({~psram1_sel_n, ~psram2_sel_n, ~sram_sel_n}) <= 1)
        else $error("more than one chip select active");

    ack_needs_io: assert property (@(negedge nWE) disable iff (!rst_n)
        data_oe |-> !host.io_n)
        else $error("data_oe high outside an I/O cycle");

    lanes_not_both_off: assert property (@(negedge nWE) disable iff (!rst_n)
        !(psram_lb_n && psram_ub_n))
        else $error("both byte lanes disabled");

endmodule

bind cart_mapper cart_mapper_sva u_sva (
    .nWE(nWE), .rst_n(rst_n), .host(host), .data_oe(data_oe),
    .psram1_sel_n(psram1_sel_n), .psram2_sel_n(psram2_sel_n), .sram_sel_n(sram_sel_n),
    .psram_lb_n(psram_lb_n), .psram_ub_n(psram_ub_n)
);

//--- bench/cart_mapper_tb.sv
`timescale 1ns/1ns

module cart_mapper_tb;

    localparam int N_RW = 40;
    localparam int N_MAP = 60;
    localparam int N_MASK = 20;
    localparam int N_POW = 10;
    localparam int NUM_OPS = 30 + 2 * N_RW + 3 * N_MAP + 6 * N_MASK + 16 + 2 * N_POW + 8;

    typedef struct packed {
        cart_pkg::port_data_t data;
        logic                 ack;
        cart_pkg::addr_ext_t  addr;
        logic [4:0]           sel;
        logic [4:0]           pow;
    } exp_t;

    logic nWE, rst_n, checking;
    cart_pkg::host_bus_t host;
    cart_pkg::port_data_t data_in, data_out;
    logic data_oe, mem_oe_n, mem_we_n, psram1_sel_n, psram2_sel_n, sram_sel_n;
    logic psram_lb_n, psram_ub_n, fastclk_enable_n, tf_pow, mcu_reset_n;
    cart_pkg::addr_ext_t addr_ext;
    logic [31:0] lfsr_state = 32'hac7a;
    int error_count = 0;
    exp_t exp_now;

    // shadow copy of the mapper registers
    cart_pkg::bank_t sh_bank [cart_pkg::NUM_WINDOWS];
    logic sh_apply [cart_pkg::NUM_WINDOWS];
    cart_pkg::rom_bank_t sh_rom_mask;
    cart_pkg::ram_bank_t sh_ram_mask;
    cart_pkg::port_data_t sh_linear;
    logic sh_self_flash, sh_mcu, sh_sram, sh_tf, sh_fast;

    cart_pkg::port_addr_t known_ports [14] = '{
        cart_pkg::PORT_LINEAR_OFF, cart_pkg::PORT_RAM_BANK, cart_pkg::PORT_ROM_BANK_0,
        cart_pkg::PORT_ROM_BANK_1, cart_pkg::PORT_MEMORY_CTRL, cart_pkg::PORT_RAM_BANK_L,
        cart_pkg::PORT_RAM_BANK_H, cart_pkg::PORT_ROM_BANK_0_L, cart_pkg::PORT_ROM_BANK_0_H,
        cart_pkg::PORT_ROM_BANK_1_L, cart_pkg::PORT_ROM_BANK_1_H, cart_pkg::PORT_POW_CNT,
        cart_pkg::PORT_BANK_MASK_LO, cart_pkg::PORT_BANK_MASK_HI};

    cart_mapper dut0 (.*);

    initial begin
        nWE = 1'b0;
        forever #4 nWE = ~nWE;
    end

    initial begin
        #((NUM_OPS + 50) * 8);
        $display("simulation timed out before all tests finished");
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) lfsr_state = lfsr_state ^ 32'h80200003;
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) v = {v[30:0], lfsr_bit()};
        return v;
    endfunction

    function automatic cart_pkg::rom_bank_t rom_view(input int w);
        return sh_apply[w] ? (sh_bank[w][8:0] & sh_rom_mask) : sh_bank[w][8:0];
    endfunction

    function automatic cart_pkg::ram_bank_t ram_view(input int w);
        return sh_apply[w] ? (sh_bank[w][3:0] & sh_ram_mask) : sh_bank[w][3:0];
    endfunction

    function automatic exp_t expected_outputs(input cart_pkg::host_bus_t h);
        exp_t e;
        cart_pkg::rom_bank_t rb;
        cart_pkg::ram_bank_t rmb;
        logic known, rom_sp, ram_sp, ram_area, mem;
        e = '0;
        known = 1'b1;
        case ({h.addr_hi, h.addr_lo[3:0]})
            cart_pkg::PORT_LINEAR_OFF: e.data = sh_linear;
            cart_pkg::PORT_RAM_BANK, cart_pkg::PORT_RAM_BANK_L: e.data = sh_bank[0][7:0];
            cart_pkg::PORT_ROM_BANK_0, cart_pkg::PORT_ROM_BANK_0_L: e.data = sh_bank[1][7:0];
            cart_pkg::PORT_ROM_BANK_1, cart_pkg::PORT_ROM_BANK_1_L: e.data = sh_bank[2][7:0];
            cart_pkg::PORT_RAM_BANK_H: e.data = {6'h00, sh_bank[0][9:8]};
            cart_pkg::PORT_ROM_BANK_0_H: e.data = {6'h00, sh_bank[1][9:8]};
            cart_pkg::PORT_ROM_BANK_1_H: e.data = {6'h00, sh_bank[2][9:8]};
            cart_pkg::PORT_MEMORY_CTRL: e.data = {7'h00, sh_self_flash};
            cart_pkg::PORT_BANK_MASK_LO: e.data = sh_rom_mask[7:0];
            cart_pkg::PORT_BANK_MASK_HI:
                e.data = {sh_ram_mask, sh_apply[0], sh_apply[2], sh_apply[1], sh_rom_mask[8]};
            cart_pkg::PORT_POW_CNT: e.data = {sh_mcu, sh_sram, 4'h0, sh_tf, sh_fast};
            default: known = 1'b0;
        endcase
        e.ack = known & !h.sel_n & !h.io_n & !h.oe_n;
        rb = '0;
        rom_sp = 1'b0;
        ram_sp = 1'b0;
        ram_area = (h.addr_hi == 4'h1);
        if (h.addr_hi == 4'h1) begin
            rom_sp = sh_self_flash;
            ram_sp = !sh_self_flash;
            rb = rom_view(cart_pkg::WIN_RAM);
        end else if (h.addr_hi == 4'h2 || h.addr_hi == 4'h3) begin
            rom_sp = 1'b1;
            rb = rom_view(h.addr_hi == 4'h2 ? cart_pkg::WIN_ROM0 : cart_pkg::WIN_ROM1);
        end else if (h.addr_hi != 4'h0) begin
            rom_sp = 1'b1;
            rb = {sh_linear[4:0], h.addr_hi};
        end
        rmb = ram_view(cart_pkg::WIN_RAM);
        mem = !h.sel_n && h.io_n;
        e.addr = {rb[6:3], rom_sp ? rb[2:0] : rmb[2:0]};
        e.sel = {!(mem && rom_sp && rb[8:7] == 2'd0), !(mem && rom_sp && rb[8:7] == 2'd1),
                 !(mem && ram_sp && !rmb[3] && sh_sram),
                 ram_area && h.addr_lo[0], ram_area && !h.addr_lo[0]};
        e.pow = {2'b00, !sh_fast, sh_tf, sh_mcu};
        return e;
    endfunction

    always @(posedge nWE or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < cart_pkg::NUM_WINDOWS; w++) begin
                sh_bank[w] = cart_pkg::BANK_RESET;
                sh_apply[w] = 1'b1;
            end
            sh_rom_mask = cart_pkg::ROM_MASK_RESET;
            sh_ram_mask = cart_pkg::RAM_MASK_RESET;
            sh_linear = cart_pkg::LINEAR_RESET;
            {sh_self_flash, sh_mcu, sh_sram, sh_tf, sh_fast} = 5'b01101;
        end else if (!host.sel_n && !host.io_n) begin
            case ({host.addr_hi, host.addr_lo[3:0]})
                cart_pkg::PORT_LINEAR_OFF: sh_linear = data_in;
                cart_pkg::PORT_RAM_BANK, cart_pkg::PORT_RAM_BANK_L: sh_bank[0][7:0] = data_in;
                cart_pkg::PORT_ROM_BANK_0, cart_pkg::PORT_ROM_BANK_0_L: sh_bank[1][7:0] = data_in;
                cart_pkg::PORT_ROM_BANK_1, cart_pkg::PORT_ROM_BANK_1_L: sh_bank[2][7:0] = data_in;
                cart_pkg::PORT_RAM_BANK_H: sh_bank[0][9:8] = data_in[1:0];
                cart_pkg::PORT_ROM_BANK_0_H: sh_bank[1][9:8] = data_in[1:0];
                cart_pkg::PORT_ROM_BANK_1_H: sh_bank[2][9:8] = data_in[1:0];
                cart_pkg::PORT_MEMORY_CTRL: sh_self_flash = data_in[0];
                cart_pkg::PORT_BANK_MASK_LO: sh_rom_mask[7:0] = data_in;
                cart_pkg::PORT_BANK_MASK_HI: begin
                    sh_rom_mask[8] = data_in[0];
                    {sh_apply[0], sh_apply[2], sh_apply[1]} = data_in[3:1];
                    sh_ram_mask = data_in[7:4];
                end
                cart_pkg::PORT_POW_CNT: begin
                    {sh_mcu, sh_sram} = data_in[7:6];
                    {sh_tf, sh_fast} = data_in[1:0];
                end
                default: begin
                end
            endcase
        end
    end

    task automatic report(input string name, input logic [31:0] got, input logic [31:0] exp);
        error_count++;
        $display("FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
        $display("Testbench failed");
        $fatal(1, "output mismatch");
    endtask

    task automatic check_data(input string name, input cart_pkg::port_data_t got,
                              input cart_pkg::port_data_t exp);
        if (got !== exp) report(name, {24'h0, got}, {24'h0, exp});
    endtask

    task automatic check_addr(input string name, input cart_pkg::addr_ext_t got,
                              input cart_pkg::addr_ext_t exp);
        if (got !== exp) report(name, {25'h0, got}, {25'h0, exp});
    endtask

    task automatic check_bits(input string name, input logic [4:0] got, input logic [4:0] exp);
        if (got !== exp) report(name, {27'h0, got}, {27'h0, exp});
    endtask

    // outputs settle between edges so compare on the falling edge
    always @(negedge nWE) begin
        if (rst_n && checking) begin
            exp_now = expected_outputs(host);
            check_data("data_out", data_out, exp_now.data);
            check_bits("data_oe", {4'h0, data_oe}, {4'h0, exp_now.ack});
            check_addr("addr_ext", addr_ext, exp_now.addr);
            check_bits("sel_lanes", {psram1_sel_n, psram2_sel_n, sram_sel_n, psram_lb_n,
                                     psram_ub_n}, exp_now.sel);
            check_bits("pow_pins", {2'b00, fastclk_enable_n, tf_pow, mcu_reset_n}, exp_now.pow);
            check_bits("mem_strobes", {3'b000, mem_oe_n, mem_we_n}, {3'b000, host.oe_n, 1'b0});
            // mem_we_n follows nWE back high after the rising edge
            @(posedge nWE);
            #1;
            check_bits("mem_we_n", {4'h0, mem_we_n}, 5'h01);
        end
    end

    task automatic drive(input cart_pkg::host_bus_t h, input cart_pkg::port_data_t d);
        @(posedge nWE);
        host <= h;
        data_in <= d;
    endtask

    task automatic port_cycle(input cart_pkg::port_addr_t p, input cart_pkg::port_data_t d,
                              input logic rd);
        logic [31:0] r;
        r = rand_bits(5);
        drive({1'b0, !rd, 1'b0, r[4:0], p[3:0], p[7:4]}, d);
    endtask

    task automatic mem_cycle(input logic [3:0] hi, input logic [8:0] lo);
        logic [31:0] r;
        r = rand_bits(4);
        drive({r[3:1] == 3'd0, r[0], 1'b1, lo, hi}, 8'h00);
    endtask

    function automatic cart_pkg::port_data_t rand_byte();
        logic [31:0] r;
        r = rand_bits(8);
        return r[7:0];
    endfunction

    initial begin
        logic [31:0] r;
        rst_n = 1'b0;
        checking = 1'b0;
        host = {3'b111, 9'h000, 4'h0};
        data_in = '0;
        repeat (2) @(posedge nWE);
        rst_n <= 1'b1;
        checking <= 1'b1;
        // reset values and unknown ports
        foreach (known_ports[i]) port_cycle(known_ports[i], rand_byte(), 1'b1);
        port_cycle(8'hC4, rand_byte(), 1'b1);
        port_cycle(8'hD6, rand_byte(), 1'b1);
        port_cycle(8'hE0, rand_byte(), 1'b1);
        port_cycle(8'h05, rand_byte(), 1'b1);
        for (int i = 0; i < N_RW; i++) begin
            r = rand_bits(8);
            port_cycle(known_ports[1 + (r % 32'd10)], rand_byte(), 1'b0);
            port_cycle(known_ports[1 + (r % 32'd10)], rand_byte(), 1'b1);
        end
        for (int i = 0; i < N_MAP; i++) begin
            r = rand_bits(8);
            port_cycle(known_ports[r % 32'd11], rand_byte(), 1'b0);
            r = rand_bits(13);
            mem_cycle(r[3:0], r[12:4]);
            r = rand_bits(13);
            mem_cycle(r[3:0], r[12:4]);
        end
        for (int i = 0; i < N_MASK; i++) begin
            port_cycle(cart_pkg::PORT_BANK_MASK_LO, rand_byte(), 1'b0);
            port_cycle(cart_pkg::PORT_BANK_MASK_HI, rand_byte(), 1'b0);
            for (int hi = 1; hi < 4; hi++) begin
                r = rand_bits(9);
                mem_cycle(hi[3:0], r[8:0]);
            end
            r = rand_bits(13);
            mem_cycle(4'h4 + 4'(r[3:0] % 4'd12), r[12:4]);
        end
        // self flash, SRAM enable and byte lanes
        port_cycle(cart_pkg::PORT_RAM_BANK_H, 8'h00, 1'b0);
        port_cycle(cart_pkg::PORT_RAM_BANK_L, 8'h02, 1'b0);
        port_cycle(cart_pkg::PORT_MEMORY_CTRL, 8'h01, 1'b0);
        mem_cycle(4'h1, 9'h000);
        mem_cycle(4'h1, 9'h001);
        port_cycle(cart_pkg::PORT_MEMORY_CTRL, 8'h00, 1'b0);
        port_cycle(cart_pkg::PORT_POW_CNT, 8'h81, 1'b0);
        mem_cycle(4'h1, 9'h010);
        port_cycle(cart_pkg::PORT_POW_CNT, 8'hC1, 1'b0);
        mem_cycle(4'h1, 9'h011);
        mem_cycle(4'h1, 9'h012);
        for (int i = 0; i < N_POW; i++) begin
            port_cycle(cart_pkg::PORT_POW_CNT, rand_byte(), 1'b0);
            port_cycle(cart_pkg::PORT_POW_CNT, rand_byte(), 1'b1);
        end
        drive({3'b111, 9'h000, 4'h0}, 8'h00);
        repeat (2) @(negedge nWE);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- hdl/bank_window.sv
`timescale 1ns/1ns

module bank_window (
    input  logic                   nWE,
    input  logic                   rst_n,
    input  cart_pkg::bank_wr_t     wr,
    input  cart_pkg::mask_cfg_t    mask,
    output cart_pkg::window_bank_t bank
);

    cart_pkg::bank_t bank_q;
    logic            apply_q;

    always_ff @(posedge nWE or negedge rst_n) begin
        if (!rst_n) begin
            bank_q  <= cart_pkg::BANK_RESET;
            apply_q <= 1'b1;
        end else begin
            if (wr.wr_lo) begin
                bank_q[7:0] <= wr.data;
            end
            // wide high port keeps two bits only
            if (wr.wr_hi) begin
                bank_q[9:8] <= wr.data[1:0];
            end
            if (wr.wr_apply) begin
                apply_q <= wr.apply_value;
            end
        end
    end

    always_comb begin
        bank.bank  = bank_q;
        bank.apply = apply_q;
        if (apply_q) begin
            bank.rom_masked = bank_q[8:0] & mask.rom_mask;
            bank.ram_masked = bank_q[3:0] & mask.ram_mask;
        end else begin
            bank.rom_masked = bank_q[8:0];
            bank.ram_masked = bank_q[3:0];
        end
    end

endmodule

//--- hdl/cart_mapper.sv
`timescale 1ns/1ns

module cart_mapper (
    input  logic                 nWE,
    input  logic                 rst_n,
    input  cart_pkg::host_bus_t  host,
    input  cart_pkg::port_data_t data_in,
    output cart_pkg::port_data_t data_out,
    output logic                 data_oe,
    output cart_pkg::addr_ext_t  addr_ext,
    output logic                 mem_oe_n,
    output logic                 mem_we_n,
    output logic                 psram1_sel_n,
    output logic                 psram2_sel_n,
    output logic                 sram_sel_n,
    output logic                 psram_lb_n,
    output logic                 psram_ub_n,
    output logic                 fastclk_enable_n,
    output logic                 tf_pow,
    output logic                 mcu_reset_n
);

    cart_pkg::bank_wr_t     [cart_pkg::NUM_WINDOWS-1:0] bank_wr;
    cart_pkg::window_bank_t [cart_pkg::NUM_WINDOWS-1:0] banks;
    cart_pkg::mask_cfg_t                                mask_cfg;
    cart_pkg::pow_cnt_t                                 pow;
    cart_pkg::port_data_t                               linear_off;
    logic                                               self_flash;

    io_port_decode u_decode (
        .nWE        (nWE),
        .rst_n      (rst_n),
        .host       (host),
        .data_in    (data_in),
        .banks      (banks),
        .bank_wr    (bank_wr),
        .mask_cfg   (mask_cfg),
        .pow        (pow),
        .self_flash (self_flash),
        .linear_off (linear_off),
        .io_rdata   (data_out),
        .io_ack     (data_oe)
    );

    // RAM, ROM 0 and ROM 1 windows
    for (genvar w = 0; w < cart_pkg::NUM_WINDOWS; w++) begin : g_window
        bank_window u_window (
            .nWE   (nWE),
            .rst_n (rst_n),
            .wr    (bank_wr[w]),
            .mask  (mask_cfg),
            .bank  (banks[w])
        );
    end

    window_select u_select (
        .host         (host),
        .banks        (banks),
        .self_flash   (self_flash),
        .linear_off   (linear_off),
        .sram_enable  (pow.sram_enable),
        .addr_ext     (addr_ext),
        .psram1_sel_n (psram1_sel_n),
        .psram2_sel_n (psram2_sel_n),
        .sram_sel_n   (sram_sel_n),
        .psram_lb_n   (psram_lb_n),
        .psram_ub_n   (psram_ub_n)
    );

    assign mem_oe_n = host.oe_n;
    assign mem_we_n = nWE;

    assign fastclk_enable_n = ~pow.fastclk_enable;
    assign tf_pow           = pow.tf_power;
    assign mcu_reset_n      = pow.mcu_reset;

endmodule

//--- hdl/cart_pkg.sv
package cart_pkg;

    // widths with a meaning on the cartridge bus
    typedef logic [7:0] port_addr_t;
    typedef logic [7:0] port_data_t;
    typedef logic [9:0] bank_t;
    typedef logic [8:0] rom_bank_t;
    typedef logic [3:0] ram_bank_t;
    typedef logic [6:0] addr_ext_t;

    // Bandai 2001 ports
    localparam port_addr_t PORT_LINEAR_OFF   = 8'hC0;
    localparam port_addr_t PORT_RAM_BANK     = 8'hC1;
    localparam port_addr_t PORT_ROM_BANK_0   = 8'hC2;
    localparam port_addr_t PORT_ROM_BANK_1   = 8'hC3;

    // Bandai 2003 ports
    localparam port_addr_t PORT_MEMORY_CTRL  = 8'hCE;
    localparam port_addr_t PORT_RAM_BANK_L   = 8'hD0;
    localparam port_addr_t PORT_RAM_BANK_H   = 8'hD1;
    localparam port_addr_t PORT_ROM_BANK_0_L = 8'hD2;
    localparam port_addr_t PORT_ROM_BANK_0_H = 8'hD3;
    localparam port_addr_t PORT_ROM_BANK_1_L = 8'hD4;
    localparam port_addr_t PORT_ROM_BANK_1_H = 8'hD5;

    // cartridge extension ports
    localparam port_addr_t PORT_POW_CNT      = 8'hE2;
    localparam port_addr_t PORT_BANK_MASK_LO = 8'hE4;
    localparam port_addr_t PORT_BANK_MASK_HI = 8'hE5;

    // magic byte that software writes to POW_CNT when extensions are locked
    // the mapper takes every POW_CNT write so this value only documents the protocol
    localparam port_data_t POW_UNLOCK = 8'hFD;

    // bank window slots
    localparam int WIN_RAM     = 0;
    localparam int WIN_ROM0    = 1;
    localparam int WIN_ROM1    = 2;
    localparam int NUM_WINDOWS = 3;

    localparam bank_t      BANK_RESET     = 10'h3FF;
    localparam rom_bank_t  ROM_MASK_RESET = 9'h1FF;
    localparam ram_bank_t  RAM_MASK_RESET = 4'hF;
    localparam port_data_t LINEAR_RESET   = 8'hFF;

    typedef struct packed {
        logic       sel_n;
        logic       oe_n;
        logic       io_n;
        logic [8:0] addr_lo;
        logic [3:0] addr_hi;
    } host_bus_t;

    // write strobes from the port decoder into one window
    typedef struct packed {
        logic       wr_lo;
        logic       wr_hi;
        logic       wr_apply;
        logic       apply_value;
        port_data_t data;
    } bank_wr_t;

    typedef struct packed {
        rom_bank_t rom_mask;
        ram_bank_t ram_mask;
    } mask_cfg_t;

    typedef struct packed {
        bank_t     bank;
        logic      apply;
        rom_bank_t rom_masked;
        ram_bank_t ram_masked;
    } window_bank_t;

    // mcu_reset is the active-low reset level driven to the MCU
    typedef struct packed {
        logic mcu_reset;
        logic sram_enable;
        logic tf_power;
        logic fastclk_enable;
    } pow_cnt_t;

endpackage

//--- hdl/io_port_decode.sv
`timescale 1ns/1ns

module io_port_decode (
    input  logic                                             nWE,
    input  logic                                             rst_n,
    input  cart_pkg::host_bus_t                              host,
    input  cart_pkg::port_data_t                             data_in,
    input  cart_pkg::window_bank_t [cart_pkg::NUM_WINDOWS-1:0] banks,
    output cart_pkg::bank_wr_t     [cart_pkg::NUM_WINDOWS-1:0] bank_wr,
    output cart_pkg::mask_cfg_t                              mask_cfg,
    output cart_pkg::pow_cnt_t                               pow,
    output logic                                             self_flash,
    output cart_pkg::port_data_t                             linear_off,
    output cart_pkg::port_data_t                             io_rdata,
    output logic                                             io_ack
);

    cart_pkg::port_addr_t port;
    logic                 port_wr;
    logic                 port_known;

    assign port = {host.addr_hi, host.addr_lo[3:0]};

    // nWE rising edge closes the write cycle
    assign port_wr = ~host.sel_n & ~host.io_n;

    // strobes into the three bank windows
    always_comb begin
        bank_wr = '0;
        for (int w = 0; w < cart_pkg::NUM_WINDOWS; w++) begin
            bank_wr[w].data     = data_in;
            bank_wr[w].wr_apply = port_wr && (port == cart_pkg::PORT_BANK_MASK_HI);
        end

        // short 2001 ports alias the low byte of the wide 2003 ports
        bank_wr[cart_pkg::WIN_RAM].wr_lo = port_wr &&
            (port == cart_pkg::PORT_RAM_BANK || port == cart_pkg::PORT_RAM_BANK_L);
        bank_wr[cart_pkg::WIN_ROM0].wr_lo = port_wr &&
            (port == cart_pkg::PORT_ROM_BANK_0 || port == cart_pkg::PORT_ROM_BANK_0_L);
        bank_wr[cart_pkg::WIN_ROM1].wr_lo = port_wr &&
            (port == cart_pkg::PORT_ROM_BANK_1 || port == cart_pkg::PORT_ROM_BANK_1_L);

        bank_wr[cart_pkg::WIN_RAM].wr_hi  = port_wr && (port == cart_pkg::PORT_RAM_BANK_H);
        bank_wr[cart_pkg::WIN_ROM0].wr_hi = port_wr && (port == cart_pkg::PORT_ROM_BANK_0_H);
        bank_wr[cart_pkg::WIN_ROM1].wr_hi = port_wr && (port == cart_pkg::PORT_ROM_BANK_1_H);

        // E5 holds ram mask, apply ram, apply rom1, apply rom0 and rom mask bit 8
        bank_wr[cart_pkg::WIN_ROM0].apply_value = data_in[1];
        bank_wr[cart_pkg::WIN_ROM1].apply_value = data_in[2];
        bank_wr[cart_pkg::WIN_RAM].apply_value  = data_in[3];
    end

    always_ff @(posedge nWE or negedge rst_n) begin
        if (!rst_n) begin
            linear_off        <= cart_pkg::LINEAR_RESET;
            mask_cfg.rom_mask <= cart_pkg::ROM_MASK_RESET;
            mask_cfg.ram_mask <= cart_pkg::RAM_MASK_RESET;
            self_flash        <= 1'b0;
            pow.mcu_reset      <= 1'b1;
            pow.sram_enable    <= 1'b1;
            pow.tf_power       <= 1'b0;
            pow.fastclk_enable <= 1'b1;
        end else if (port_wr) begin
            case (port)
                cart_pkg::PORT_LINEAR_OFF: linear_off <= data_in;
                cart_pkg::PORT_MEMORY_CTRL: self_flash <= data_in[0];
                cart_pkg::PORT_BANK_MASK_LO: mask_cfg.rom_mask[7:0] <= data_in;
                cart_pkg::PORT_BANK_MASK_HI: begin
                    mask_cfg.rom_mask[8] <= data_in[0];
                    mask_cfg.ram_mask    <= data_in[7:4];
                end
                cart_pkg::PORT_POW_CNT: begin
                    pow.fastclk_enable <= data_in[0];
                    pow.tf_power       <= data_in[1];
                    pow.sram_enable    <= data_in[6];
                    pow.mcu_reset      <= data_in[7];
                end
                default: begin
                end
            endcase
        end
    end

    // readback mux
    always_comb begin
        port_known = 1'b1;
        io_rdata   = '0;
        case (port)
            cart_pkg::PORT_LINEAR_OFF: io_rdata = linear_off;
            cart_pkg::PORT_RAM_BANK,
            cart_pkg::PORT_RAM_BANK_L: io_rdata = banks[cart_pkg::WIN_RAM].bank[7:0];
            cart_pkg::PORT_ROM_BANK_0,
            cart_pkg::PORT_ROM_BANK_0_L: io_rdata = banks[cart_pkg::WIN_ROM0].bank[7:0];
            cart_pkg::PORT_ROM_BANK_1,
            cart_pkg::PORT_ROM_BANK_1_L: io_rdata = banks[cart_pkg::WIN_ROM1].bank[7:0];
            cart_pkg::PORT_RAM_BANK_H:
                io_rdata = {6'h00, banks[cart_pkg::WIN_RAM].bank[9:8]};
            cart_pkg::PORT_ROM_BANK_0_H:
                io_rdata = {6'h00, banks[cart_pkg::WIN_ROM0].bank[9:8]};
            cart_pkg::PORT_ROM_BANK_1_H:
                io_rdata = {6'h00, banks[cart_pkg::WIN_ROM1].bank[9:8]};
            cart_pkg::PORT_MEMORY_CTRL: io_rdata = {7'h00, self_flash};
            cart_pkg::PORT_BANK_MASK_LO: io_rdata = mask_cfg.rom_mask[7:0];
            cart_pkg::PORT_BANK_MASK_HI: io_rdata = {mask_cfg.ram_mask,
                                                     banks[cart_pkg::WIN_RAM].apply,
                                                     banks[cart_pkg::WIN_ROM1].apply,
                                                     banks[cart_pkg::WIN_ROM0].apply,
                                                     mask_cfg.rom_mask[8]};
            // extension enable bits 5:2 read as zero
            cart_pkg::PORT_POW_CNT: io_rdata = {pow.mcu_reset, pow.sram_enable, 4'h0,
                                                pow.tf_power, pow.fastclk_enable};
            default: port_known = 1'b0;
        endcase
    end

    assign io_ack = port_known & ~host.sel_n & ~host.io_n & ~host.oe_n;

endmodule

//--- hdl/window_select.sv
`timescale 1ns/1ns

module window_select (
    input  cart_pkg::host_bus_t                                host,
    input  cart_pkg::window_bank_t [cart_pkg::NUM_WINDOWS-1:0] banks,
    input  logic                                               self_flash,
    input  cart_pkg::port_data_t                               linear_off,
    input  logic                                               sram_enable,
    output cart_pkg::addr_ext_t                                addr_ext,
    output logic                                               psram1_sel_n,
    output logic                                               psram2_sel_n,
    output logic                                               sram_sel_n,
    output logic                                               psram_lb_n,
    output logic                                               psram_ub_n
);

    cart_pkg::rom_bank_t rom_bank;
    cart_pkg::ram_bank_t ram_bank;
    logic                sel_rom_space;
    logic                sel_ram_space;
    logic                ram_area;
    logic                mem_access;

    always_comb begin
        rom_bank      = '0;
        sel_rom_space = 1'b0;
        sel_ram_space = 1'b0;
        ram_area      = 1'b0;
        case (host.addr_hi)
            4'h0: begin
            end
            4'h1: begin
                // self flash maps the RAM window onto PSRAM
                sel_rom_space = self_flash;
                sel_ram_space = ~self_flash;
                ram_area      = 1'b1;
                rom_bank      = banks[cart_pkg::WIN_RAM].rom_masked;
            end
            4'h2: begin
                sel_rom_space = 1'b1;
                rom_bank      = banks[cart_pkg::WIN_ROM0].rom_masked;
            end
            4'h3: begin
                sel_rom_space = 1'b1;
                rom_bank      = banks[cart_pkg::WIN_ROM1].rom_masked;
            end
            default: begin
                sel_rom_space = 1'b1;
                rom_bank      = {linear_off[4:0], host.addr_hi};
            end
        endcase
    end

    // SRAM banking always goes through the RAM window
    assign ram_bank = banks[cart_pkg::WIN_RAM].ram_masked;

    assign mem_access = ~host.sel_n & host.io_n;

    assign psram1_sel_n = ~(mem_access & sel_rom_space & (rom_bank[8:7] == 2'd0));
    assign psram2_sel_n = ~(mem_access & sel_rom_space & (rom_bank[8:7] == 2'd1));
    assign sram_sel_n   = ~(mem_access & sel_ram_space & ~ram_bank[3] & sram_enable);

    assign addr_ext[2:0] = sel_rom_space ? rom_bank[2:0] : ram_bank[2:0];
    // SRAM ignores bits above 2 so these always follow the ROM bank
    assign addr_ext[6:3] = rom_bank[6:3];

    // odd addresses in the RAM area hit the upper byte lane
    assign psram_lb_n = ram_area & host.addr_lo[0];
    assign psram_ub_n = ram_area & ~host.addr_lo[0];

endmodule
